// File: src.f
hw/modexp_pkg.sv
hw/modexp_job_if.sv
hw/modexp_lane.sv
hw/modexp_dispatch.sv
hw/modexp_collect.sv
hw/modexp_regs.sv
hw/modexp_apb_top.sv
bench/modexp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the modexp testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module modexp_tb -f src.f -o Vmodexp_tb

# An RTL assertion may stop the run early, the log decides
./obj_dir/Vmodexp_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: bench/modexp_tb.sv
`timescale 1ns/100ps

module modexp_tb;

	// Jobs issued over all tests for the watchdog budget
	localparam int N_JOBS = 21;
	// STATUS reads before a done bit is given up on
	localparam int POLL_LIMIT = 200;

	logic apb;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	integer seed;
	int n_checks;
	int n_errors;
	// Failures found outside the checker
	int n_misc;
	int last_waits;
	int rd_idx;

	// Pending comparisons appended by stimulus
	string name_q[$];
	logic [31:0] got_q[$];
	logic [31:0] want_q[$];

	modexp_apb_top modexp_apb_top_inst (
		.apb(apb),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	// 20 ns period
	always #10 apb = ~apb;

	////////////////////////////////////////////////////////////
	// Reference model

	// Square and multiply MSB first with 64-bit products
	function automatic logic [31:0] ref_modexp(input logic [31:0] base, input logic [31:0] exp);
		logic [63:0] acc;
		logic [63:0] b;
		logic [63:0] p;
		p = {32'h0, modexp_pkg::P_MOD};
		b = {32'h0, base} % p;
		acc = 64'd1;
		for (int i = 31; i >= 0; i--) begin
			acc = (acc * acc) % p;
			if (exp[i])
				acc = (acc * b) % p;
		end
		return acc[31:0];
	endfunction

	// RESULT word address of a tag from the address fields
	function automatic logic [31:0] result_addr(input int tag);
		modexp_pkg::apb_addr_u a;
		a.fields.block = modexp_pkg::BLOCK_RESULT;
		a.fields.index = tag[2:0];
		a.fields.byte_sel = 2'b00;
		return {24'h0, a.raw};
	endfunction

	////////////////////////////////////////////////////////////
	// APB master

	// Setup phase then access phase held until pready
	task automatic apb_access(input logic wr, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge apb);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge apb);
		#2;
		penable = 1'b1;
		last_waits = 0;
		// Mid-cycle sampling
		@(negedge apb);
		while (!pready) begin
			last_waits++;
			@(negedge apb);
		end
		rdata = prdata;
		err = pslverr;
		// Only CMD writes may stretch
		if (!(wr && addr == modexp_pkg::REG_CMD))
			check("pready wait states", 32'(last_waits), 32'h0);
		@(posedge apb);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
		apb_access(1'b0, addr, 32'h0, data, err);
	endtask

	////////////////////////////////////////////////////////////
	// Checking

	// Queue one comparison for the checker
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		name_q.push_back(name);
		got_q.push_back(got);
		want_q.push_back(want);
	endtask

	// Drains new entries each rising edge
	always @(posedge apb) begin
		while (rd_idx < want_q.size()) begin
			n_checks++;
			assert (got_q[rd_idx] == want_q[rd_idx])
			else begin
				$display("Fail at %0t: %s got %h expected %h", $time, name_q[rd_idx],
					got_q[rd_idx], want_q[rd_idx]);
				n_errors++;
			end
			rd_idx++;
		end
	end

	// Poll STATUS until every bit of mask is set
	task automatic wait_done(input logic [7:0] mask);
		logic [31:0] st;
		logic err;
		int polls;
		polls = 0;
		st = 32'h0;
		while ((st[7:0] & mask) != mask && polls < POLL_LIMIT) begin
			apb_read(modexp_pkg::REG_STATUS, st, err);
			polls++;
		end
		assert ((st[7:0] & mask) == mask)
		else begin
			$display("Done bits %h never set, STATUS stayed at %h", mask, st);
			n_misc++;
		end
	endtask

	// Full job on one tag followed by clearing its done bit
	task automatic single_job(input logic [31:0] base, input logic [31:0] exp, input int tag);
		logic [31:0] res;
		logic err;
		apb_write(modexp_pkg::REG_BASE, base, err);
		check("pslverr on BASE write", 32'(err), 32'h0);
		apb_write(modexp_pkg::REG_EXP, exp, err);
		apb_write(modexp_pkg::REG_CMD, 32'(tag), err);
		check("pslverr on CMD write", 32'(err), 32'h0);
		wait_done(8'h1 << tag);
		apb_read(result_addr(tag), res, err);
		check($sformatf("prdata RESULT[%0d]", tag), res, ref_modexp(base, exp));
		apb_write(modexp_pkg::REG_STATUS, 32'h1 << tag, err);
	endtask

	// Report the test once the checker has caught up
	task automatic end_test(input int num, input string title, input int mark);
		int errs;
		repeat (2) @(negedge apb);
		errs = n_errors + n_misc - mark;
		if (errs == 0)
			$display("Test %0d %s: ok", num, title);
		else
			$display("Test %0d %s: %0d error(s)", num, title, errs);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic [31:0] rdata;
		logic err;
		logic [31:0] t2_base [3];
		logic [31:0] t2_exp [4];
		logic [31:0] t3_base [8];
		logic [31:0] t3_exp [8];
		int mark;
		int max_waits;
		apb = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 32'h0;
		pwdata = 32'h0;
		seed = 32'h43db5b8f;
		n_checks = 0;
		n_errors = 0;
		n_misc = 0;
		rd_idx = 0;
		repeat (5) @(posedge apb);
		#2;
		rst_n = 1'b1;

		// Reset state and basic access
		mark = 0;
		apb_read(modexp_pkg::REG_STATUS, rdata, err);
		check("prdata STATUS", rdata, 32'h0);
		check("pslverr on STATUS read", 32'(err), 32'h0);
		apb_write(modexp_pkg::REG_BASE, 32'h0000_1234, err);
		check("pslverr on BASE write", 32'(err), 32'h0);
		apb_read(modexp_pkg::REG_BASE, rdata, err);
		check("prdata BASE", rdata, 32'h0000_1234);
		check("pslverr on BASE read", 32'(err), 32'h0);
		apb_read(modexp_pkg::REG_CMD, rdata, err);
		check("pslverr on CMD read", 32'(err), 32'h1);
		end_test(1, "reset and register access", mark);

		// Corner operands one job at a time
		mark = n_errors + n_misc;
		t2_base[0] = 32'h0;
		t2_base[1] = 32'h1;
		t2_base[2] = modexp_pkg::P_MOD - 32'h1;
		t2_exp[0] = 32'h0;
		t2_exp[1] = 32'h1;
		t2_exp[2] = 32'h2;
		t2_exp[3] = 32'hFFFF_FFFF;
		for (int e = 0; e < 4; e++) begin
			for (int b = 0; b < 3; b++)
				single_job(t2_base[b], t2_exp[e], (e * 3 + b) % 8);
		end
		end_test(2, "single jobs", mark);

		// Back to back jobs outnumbering the lanes
		mark = n_errors + n_misc;
		max_waits = 0;
		for (int t = 0; t < 8; t++) begin
			t3_base[t] = $unsigned($random(seed)) % modexp_pkg::P_MOD;
			t3_exp[t] = $random(seed);
			apb_write(modexp_pkg::REG_BASE, t3_base[t], err);
			check("pslverr on BASE write", 32'(err), 32'h0);
			apb_write(modexp_pkg::REG_EXP, t3_exp[t], err);
			apb_write(modexp_pkg::REG_CMD, 32'(t), err);
			check("pslverr on CMD write", 32'(err), 32'h0);
			if (last_waits > max_waits)
				max_waits = last_waits;
		end
		check("CMD write stalled at least once", 32'(max_waits > 0), 32'h1);
		// Last job still in flight
		apb_read(modexp_pkg::REG_STATUS, rdata, err);
		check("prdata STATUS busy bit", 32'(rdata[8]), 32'h1);
		wait_done(8'hFF);
		for (int t = 0; t < 8; t++) begin
			apb_read(result_addr(t), rdata, err);
			check($sformatf("prdata RESULT[%0d]", t), rdata, ref_modexp(t3_base[t], t3_exp[t]));
		end
		end_test(3, "back to back jobs", mark);

		// Write-one-to-clear half the bits at a time
		mark = n_errors + n_misc;
		apb_write(modexp_pkg::REG_STATUS, 32'h55, err);
		apb_read(modexp_pkg::REG_STATUS, rdata, err);
		check("prdata STATUS", rdata, 32'hAA);
		apb_write(modexp_pkg::REG_STATUS, 32'hAA, err);
		apb_read(modexp_pkg::REG_STATUS, rdata, err);
		check("prdata STATUS", rdata, 32'h0);
		end_test(4, "done bit clear", mark);

		// Rejected base and out of map accesses
		mark = n_errors + n_misc;
		apb_write(modexp_pkg::REG_BASE, 32'h0001_E240, err);
		check("pslverr on BASE write", 32'(err), 32'h0);
		apb_write(modexp_pkg::REG_BASE, modexp_pkg::P_MOD, err);
		check("pslverr on BASE write of P_MOD", 32'(err), 32'h1);
		apb_write(modexp_pkg::REG_BASE, 32'hFFFF_FFFF, err);
		check("pslverr on BASE write of all ones", 32'(err), 32'h1);
		apb_read(modexp_pkg::REG_BASE, rdata, err);
		check("prdata BASE", rdata, 32'h0001_E240);
		apb_read(32'h40, rdata, err);
		check("pslverr on read above map", 32'(err), 32'h1);
		apb_write(32'h100, 32'h0, err);
		check("pslverr on write above map", 32'(err), 32'h1);
		// Job must still use the accepted base
		apb_write(modexp_pkg::REG_EXP, 32'h0000_BEEF, err);
		apb_write(modexp_pkg::REG_CMD, 32'h5, err);
		check("pslverr on CMD write", 32'(err), 32'h0);
		wait_done(8'h20);
		apb_read(result_addr(5), rdata, err);
		check("prdata RESULT[5]", rdata, ref_modexp(32'h0001_E240, 32'h0000_BEEF));
		apb_write(modexp_pkg::REG_STATUS, 32'h20, err);
		end_test(5, "error responses", mark);

		$display("Checks run: %0d, errors: %0d", n_checks, n_errors + n_misc);
		if (n_errors + n_misc == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Generous budget per job plus setup
	initial begin
		repeat (N_JOBS * 200 + 2000) @(posedge apb);
		$display("Watchdog expired before the tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: hw/modexp_apb_top.sv
`timescale 1ns/100ps

module modexp_apb_top (
	input logic apb,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

	// Status and readback between regs and collector
	logic [modexp_pkg::N_TAGS-1:0] done_mask;
	logic [modexp_pkg::N_TAGS-1:0] clr_mask;
	logic [modexp_pkg::TAG_W-1:0] rd_tag;
	logic [31:0] rd_data;
	logic busy;

	////////////////////////////////////////////////////////////
	// Job paths

	modexp_job_if job_req ();
	modexp_job_if lane_job [modexp_pkg::N_LANES] ();
	modexp_job_if lane_res [modexp_pkg::N_LANES] ();

	modexp_regs modexp_regs_inst (
		.apb(apb),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.done_mask(done_mask),
		.rd_data(rd_data),
		.rd_tag(rd_tag),
		.clr_mask(clr_mask),
		.busy(busy),
		.job_req(job_req)
	);

	// Dispatcher also watches lane results to track idle lanes
	modexp_dispatch modexp_dispatch_inst (
		.apb(apb),
		.rst_n(rst_n),
		.busy(busy),
		.job_req(job_req),
		.lane_job(lane_job),
		.lane_mon(lane_res)
	);

	////////////////////////////////////////////////////////////
	// Exponentiation lanes

	for (genvar i = 0; i < modexp_pkg::N_LANES; i++) begin : g_lane
		modexp_lane modexp_lane_inst (
			.apb(apb),
			.rst_n(rst_n),
			.job(lane_job[i]),
			.res(lane_res[i])
		);
	end

	modexp_collect modexp_collect_inst (
		.apb(apb),
		.rst_n(rst_n),
		.rd_tag(rd_tag),
		.clr_mask(clr_mask),
		.done_mask(done_mask),
		.rd_data(rd_data),
		.lane_res(lane_res)
	);

endmodule

// File: hw/modexp_regs.sv
`timescale 1ns/100ps

module modexp_regs (
	input logic apb,
	input logic rst_n,

	// APB completer
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,

	// Collector side
	input logic [modexp_pkg::N_TAGS-1:0] done_mask,
	input logic [31:0] rd_data,
	output logic [modexp_pkg::TAG_W-1:0] rd_tag,
	output logic [modexp_pkg::N_TAGS-1:0] clr_mask,

	// Dispatcher side
	input logic busy,
	modexp_job_if.src job_req
);

	////////////////////////////////////////////////////////////
	// Address decode

	modexp_pkg::apb_addr_u addr;
	logic [31:0] reg_off;
	logic in_map;
	logic access;

	logic hit_base;
	logic hit_exp;
	logic hit_cmd;
	logic hit_status;
	logic hit_result;

	logic base_bad;
	logic wr_ok;

	logic [31:0] base_q;
	logic [31:0] exp_q;

	assign addr.raw = paddr[7:0];
	assign reg_off = {24'h0, addr.raw};

	// Anything above the map is an error
	assign in_map = (paddr <= modexp_pkg::REG_LAST);

	// Access phase of a transfer
	assign access = psel && penable;

	assign hit_base = in_map && (reg_off == modexp_pkg::REG_BASE);
	assign hit_exp = in_map && (reg_off == modexp_pkg::REG_EXP);
	assign hit_cmd = in_map && (reg_off == modexp_pkg::REG_CMD);
	assign hit_status = in_map && (reg_off == modexp_pkg::REG_STATUS);
	// Whole RESULT window by block field
	assign hit_result = in_map && (addr.fields.block == modexp_pkg::BLOCK_RESULT);

	// Base must already be reduced
	assign base_bad = hit_base && (pwdata >= modexp_pkg::P_MOD);

	////////////////////////////////////////////////////////////
	// Response

	always_comb begin
		pslverr = 1'b0;
		if (access) begin
			if (!in_map)
				pslverr = 1'b1;
			else if (pwrite && base_bad)
				pslverr = 1'b1;
			// CMD is write only
			else if (!pwrite && hit_cmd)
				pslverr = 1'b1;
		end
	end

	// CMD writes stretch until the dispatcher takes the job
	assign pready = access && !(pwrite && hit_cmd && !job_req.ready);

	// Read mux
	always_comb begin
		prdata = 32'h0;
		if (access && !pwrite) begin
			if (hit_base)
				prdata = base_q;
			else if (hit_exp)
				prdata = exp_q;
			else if (hit_status)
				prdata = 32'({busy, done_mask});
			else if (hit_result)
				prdata = rd_data;
		end
	end

	// Table lookup follows the word index
	assign rd_tag = addr.fields.index;

	////////////////////////////////////////////////////////////
	// Writes

	// Completed error-free write
	assign wr_ok = access && pwrite && pready && !pslverr;

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			base_q <= 32'h0;
			exp_q <= 32'h0;
		end else begin
			// Rejected bases leave the old value in place
			if (wr_ok && hit_base)
				base_q <= pwdata;
			if (wr_ok && hit_exp)
				exp_q <= pwdata;
		end
	end

	// Single-cycle clear pulse, zero wait state access
	assign clr_mask = (wr_ok && hit_status) ? pwdata[modexp_pkg::N_TAGS-1:0] : '0;

	////////////////////////////////////////////////////////////
	// Job issue

	// Held by the APB master while the access is stretched
	assign job_req.valid = access && pwrite && hit_cmd;
	assign job_req.base = base_q;
	assign job_req.exp = exp_q;
	assign job_req.tag = pwdata[modexp_pkg::TAG_W-1:0];

	// Stalled job keeps its operands
	assert property (@(posedge apb) disable iff (!rst_n)
		job_req.valid && !job_req.ready |=>
			job_req.valid && $stable(job_req.base) && $stable(job_req.exp) &&
			$stable(job_req.tag))
		else $error("job_req changed while stalled");

endmodule

// File: hw/modexp_collect.sv
`timescale 1ns/100ps

module modexp_collect (
	input logic apb,
	input logic rst_n,
	input logic [modexp_pkg::TAG_W-1:0] rd_tag,
	input logic [modexp_pkg::N_TAGS-1:0] clr_mask,
	output logic [modexp_pkg::N_TAGS-1:0] done_mask,
	output logic [31:0] rd_data,
	modexp_job_if.dst lane_res [modexp_pkg::N_LANES]
);

	// Lane results flattened
	logic [modexp_pkg::N_LANES-1:0] res_vld;
	logic [modexp_pkg::N_LANES-1:0] res_rdy;
	logic [31:0] res_val [modexp_pkg::N_LANES];
	logic [modexp_pkg::TAG_W-1:0] res_tag [modexp_pkg::N_LANES];

	// Arbiter
	logic [modexp_pkg::LANE_W-1:0] ptr;
	logic [modexp_pkg::LANE_W-1:0] gnt_idx;
	logic [modexp_pkg::LANE_W-1:0] idx;
	logic gnt_vld;

	logic [modexp_pkg::N_TAGS-1:0] set_mask;
	logic [31:0] res_table [modexp_pkg::N_TAGS];

	for (genvar i = 0; i < modexp_pkg::N_LANES; i++) begin : g_lane
		assign res_vld[i] = lane_res[i].valid;
		assign res_val[i] = lane_res[i].base;
		assign res_tag[i] = lane_res[i].tag;
		assign lane_res[i].ready = res_rdy[i];

		// Waiting result must hold still until drained
		assert property (@(posedge apb) disable iff (!rst_n)
			res_vld[i] && !res_rdy[i] |=>
				res_vld[i] && $stable(res_val[i]) && $stable(res_tag[i]))
			else $error("lane %0d result changed while waiting", i);
	end

	////////////////////////////////////////////////////////////
	// Round robin grant

	// Scan backward from ptr so the nearest valid lane writes last
	always_comb begin
		gnt_vld = 1'b0;
		gnt_idx = ptr;
		idx = ptr;
		for (int k = modexp_pkg::N_LANES - 1; k >= 0; k--) begin
			idx = ptr + k[modexp_pkg::LANE_W-1:0];
			if (res_vld[idx]) begin
				gnt_vld = 1'b1;
				gnt_idx = idx;
			end
		end
	end

	always_comb begin
		res_rdy = '0;
		if (gnt_vld)
			res_rdy[gnt_idx] = 1'b1;
	end

	// Granted lane goes to the back
	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n)
			ptr <= '0;
		else if (gnt_vld)
			ptr <= gnt_idx + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Result table and done bits

	always_comb begin
		set_mask = '0;
		if (gnt_vld)
			set_mask[res_tag[gnt_idx]] = 1'b1;
	end

	always_ff @(posedge apb) begin
		// Reused tag overwrites
		if (gnt_vld)
			res_table[res_tag[gnt_idx]] <= res_val[gnt_idx];
	end

	// New completion beats a clear
	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n)
			done_mask <= '0;
		else
			done_mask <= (done_mask & ~clr_mask) | set_mask;
	end

	assign rd_data = res_table[rd_tag];

endmodule

// File: hw/modexp_dispatch.sv
`timescale 1ns/100ps

module modexp_dispatch (
	input logic apb,
	input logic rst_n,
	output logic busy,
	modexp_job_if.dst job_req,
	modexp_job_if.src lane_job [modexp_pkg::N_LANES],
	modexp_job_if.mon lane_mon [modexp_pkg::N_LANES]
);

	// Holding slot
	logic slot_vld;
	logic [31:0] slot_base;
	logic [31:0] slot_exp;
	logic [modexp_pkg::TAG_W-1:0] slot_tag;

	// Per lane flags
	logic [modexp_pkg::N_LANES-1:0] idle;
	logic [modexp_pkg::N_LANES-1:0] lane_vld;
	logic [modexp_pkg::N_LANES-1:0] lane_rdy;
	logic [modexp_pkg::N_LANES-1:0] lane_done;
	logic [modexp_pkg::N_LANES-1:0] taken;

	logic [modexp_pkg::LANE_W-1:0] sel;

	// One job at a time
	assign job_req.ready = !slot_vld;

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n)
			slot_vld <= 1'b0;
		else if (job_req.valid && job_req.ready)
			slot_vld <= 1'b1;
		else if (|taken)
			slot_vld <= 1'b0;
	end

	always_ff @(posedge apb) begin
		if (job_req.valid && job_req.ready) begin
			slot_base <= job_req.base;
			slot_exp <= job_req.exp;
			slot_tag <= job_req.tag;
		end
	end

	// Lowest idle lane wins
	always_comb begin
		sel = '0;
		for (int i = modexp_pkg::N_LANES - 1; i >= 0; i--) begin
			if (idle[i])
				sel = i[modexp_pkg::LANE_W-1:0];
		end
	end

	always_comb begin
		lane_vld = '0;
		if (slot_vld && |idle)
			lane_vld[sel] = 1'b1;
	end

	assign taken = lane_vld & lane_rdy;

	////////////////////////////////////////////////////////////
	// Lane fan-out

	for (genvar i = 0; i < modexp_pkg::N_LANES; i++) begin : g_lane
		assign lane_job[i].valid = lane_vld[i];
		assign lane_job[i].base = slot_base;
		assign lane_job[i].exp = slot_exp;
		assign lane_job[i].tag = slot_tag;
		assign lane_rdy[i] = lane_job[i].ready;
		// Result drained by the collector
		assign lane_done[i] = lane_mon[i].valid && lane_mon[i].ready;

		// Lane must really be idle when offered a job
		assert property (@(posedge apb) disable iff (!rst_n)
			lane_job[i].valid |-> lane_job[i].ready)
			else $error("job offered to busy lane %0d", i);
	end

	// Busy from handshake, idle again once drained
	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n)
			idle <= '1;
		else
			idle <= (idle & ~taken) | lane_done;
	end

	assign busy = slot_vld || (idle != '1);

endmodule

// File: hw/modexp_lane.sv
`timescale 1ns/100ps

module modexp_lane (
	input logic apb,
	input logic rst_n,
	modexp_job_if.dst job,
	modexp_job_if.src res
);

	////////////////////////////////////////////////////////////
	// Control

	logic run;
	logic res_vld;
	// Even steps square, odd steps multiply
	logic [5:0] step;
	logic accept;
	logic drain;

	// Operands and accumulator
	logic [31:0] acc;
	logic [31:0] base_q;
	logic [31:0] exp_q;
	logic [modexp_pkg::TAG_W-1:0] tag_q;

	// Datapath
	logic [31:0] mul_b;
	logic [63:0] prod;
	logic [33:0] fold;
	logic [31:0] red;

	assign job.ready = !run && !res_vld;
	assign accept = job.valid && job.ready;
	assign drain = res.valid && res.ready;

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			res_vld <= 1'b0;
			step <= '0;
		end else begin
			if (accept) begin
				run <= 1'b1;
				step <= '0;
			end else if (run) begin
				step <= step + 6'd1;
				// 32 bits, two steps each
				if (step == 6'd63) begin
					run <= 1'b0;
					res_vld <= 1'b1;
				end
			end
			if (drain)
				res_vld <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Multiply and reduce

	// Shared multiplier
	assign mul_b = step[0] ? base_q : acc;
	assign prod = {32'h0, acc} * {32'h0, mul_b};

	// 2^31 is 1 mod P, so add high part onto low part
	assign fold = {3'b000, prod[30:0]} + {1'b0, prod[63:31]};

	// Fold stays below 2P, one subtract is enough
	assign red = (fold >= 34'(modexp_pkg::P_MOD)) ?
		32'(fold - 34'(modexp_pkg::P_MOD)) : fold[31:0];

	always_ff @(posedge apb) begin
		if (accept) begin
			acc <= 32'd1;
			base_q <= job.base;
			exp_q <= job.exp;
			tag_q <= job.tag;
		end else if (run) begin
			if (!step[0]) begin
				acc <= red;
			end else begin
				// MSB first
				if (exp_q[31])
					acc <= red;
				exp_q <= {exp_q[30:0], 1'b0};
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Result port

	assign res.valid = res_vld;
	assign res.base = acc;
	assign res.exp = 32'h0;
	assign res.tag = tag_q;

	// Fully reduced after 64 steps
	assert property (@(posedge apb) disable iff (!rst_n)
		res.valid |-> (res.base < modexp_pkg::P_MOD))
		else $error("lane result not reduced");

endmodule

// File: hw/modexp_job_if.sv
`timescale 1ns/100ps

interface modexp_job_if;

	// Handshake pair
	logic valid;
	logic ready;

	// Job operands
	// Result value when used on the lane output side
	logic [31:0] base;
	logic [31:0] exp;
	logic [modexp_pkg::TAG_W-1:0] tag;

	// Producer side
	modport src (output valid, base, exp, tag, input ready);

	// Consumer side
	modport dst (input valid, base, exp, tag, output ready);

	// Read-only observer
	modport mon (input valid, ready, base, exp, tag);

endinterface

// File: hw/modexp_pkg.sv
package modexp_pkg;

	////////////////////////////////////////////////////////////
	// Arithmetic

	// Mersenne prime 2^31-1
	localparam logic [31:0] P_MOD = 32'h7FFF_FFFF;

	////////////////////////////////////////////////////////////
	// Lanes and result table

	localparam int N_LANES = 4;
	// Wide enough to index N_LANES
	localparam int LANE_W = 2;

	// One table entry per tag
	localparam int N_TAGS = 8;
	localparam int TAG_W = 3;

	////////////////////////////////////////////////////////////
	// Register map, byte offsets

	localparam logic [31:0] REG_BASE = 32'h00;
	localparam logic [31:0] REG_EXP = 32'h04;
	// Write issues a job, tag in bits 2:0
	localparam logic [31:0] REG_CMD = 32'h08;
	// Done bits 7:0, busy bit 8, write ones to clear
	localparam logic [31:0] REG_STATUS = 32'h0C;
	// Eight words, one per tag
	localparam logic [31:0] REG_RESULT = 32'h20;
	// End of map
	localparam logic [31:0] REG_LAST = 32'h3F;

	// Block field of the RESULT window
	localparam logic [2:0] BLOCK_RESULT = REG_RESULT[7:5];

	////////////////////////////////////////////////////////////
	// Low address byte, seen as a whole or as fields

	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [2:0] block;
			// Word within the block
			logic [2:0] index;
			logic [1:0] byte_sel;
		} fields;
	} apb_addr_u;

endpackage
